//--- verilog/game_io_pkg.sv
////////////////////
// Shared definitions of the game board I/O block
// Register address and data types
// Port register addresses and pin masks
// Timer 0 register addresses and field positions
////////////////////

package game_io_pkg;

    typedef logic [7:0] io_addr_t;
    typedef logic [7:0] io_data_t;

    localparam int NUM_PORTS = 5;

    // PIN address of each port with DDR at +1 and PORT at +2
    localparam io_addr_t PB_BASE = 8'h23;
    localparam io_addr_t PC_BASE = 8'h26;
    localparam io_addr_t PD_BASE = 8'h29;
    localparam io_addr_t PE_BASE = 8'h2C;
    localparam io_addr_t PF_BASE = 8'h2F;

    localparam io_data_t PB_PIN_MASK = 8'hF0;
    localparam io_data_t PC_PIN_MASK = 8'hC0;
    localparam io_data_t PD_PIN_MASK = 8'hD0;
    localparam io_data_t PE_PIN_MASK = 8'h40;
    localparam io_data_t PF_PIN_MASK = 8'hF3;

    localparam io_data_t PB_INV_MASK = 8'h10;  // Button B
    localparam io_data_t PC_INV_MASK = 8'h00;
    localparam io_data_t PD_INV_MASK = 8'h00;
    localparam io_data_t PE_INV_MASK = 8'h40;  // Button A
    localparam io_data_t PF_INV_MASK = 8'hF0;  // Direction keys

    localparam io_data_t PB_OUT_MASK = 8'hEF;
    localparam io_data_t PC_OUT_MASK = 8'hC0;
    localparam io_data_t PD_OUT_MASK = 8'hFF;
    localparam io_data_t PE_OUT_MASK = 8'h00;
    localparam io_data_t PF_OUT_MASK = 8'h00;

    // Timer 0 registers
    localparam io_addr_t TCCRA_ADDR = 8'h44;
    localparam io_addr_t TCCRB_ADDR = 8'h45;
    localparam io_addr_t TCNT_ADDR  = 8'h46;
    localparam io_addr_t OCRA_ADDR  = 8'h47;
    localparam io_addr_t OCRB_ADDR  = 8'h48;
    localparam io_addr_t TIMSK_ADDR = 8'h6E;
    localparam io_addr_t TIFR_ADDR  = 8'h35;

    // Flag bits share one layout in TIFR and TIMSK
    localparam int TOV_BIT  = 0;
    localparam int OCFA_BIT = 1;
    localparam int OCFB_BIT = 2;

    localparam int CS_MSB   = 2;  // TCCRB clock select
    localparam int CS_LSB   = 0;
    localparam int WGM1_BIT = 1;  // CTC mode in TCCRA
    localparam int COMA_MSB = 7;  // TCCRA compare output mode A
    localparam int COMA_LSB = 6;

    localparam int PRESCALE_WIDTH = 10;

endpackage

//--- verilog/io_bus_if.sv
////////////////////
// Internal register bus
// Bridge drives, peripherals listen
////////////////////

interface io_bus_if
    import game_io_pkg::*;
();

    io_addr_t addr;   // Held from the APB setup phase
    io_data_t wdata;
    logic     wr;     // Access cycle of a write
    logic     rd;     // Access cycle of a read

    modport bridge (
        output addr,
        output wdata,
        output wr,
        output rd
    );

    modport periph (
        input addr,
        input wdata,
        input wr,
        input rd
    );

endinterface

//--- verilog/apb_io_bridge.sv
////////////////////
// APB slave for the I/O registers
// Address hold, write and read strobes
// OR of the peripheral read data
////////////////////

module apb_io_bridge
    import game_io_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  io_addr_t                 paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  io_data_t                 pwdata,
    output io_data_t                 prdata,
    input  io_data_t [NUM_PORTS-1:0] port_rdata,
    input  io_data_t                 tim_rdata,
    io_bus_if.bridge                 bus
);

    io_addr_t addr_q;
    logic     access;

    assign access = psel && penable;  // No wait states

    // Address captured in the setup phase
    always_ff @(posedge clk)
    begin
        if (rst)
            addr_q <= '0;
        else if (psel && !penable)
            addr_q <= paddr;
    end

    assign bus.addr  = addr_q;
    assign bus.wdata = pwdata;
    assign bus.wr    = access && pwrite;
    assign bus.rd    = access && !pwrite;

    // Unselected peripherals return zero
    always_comb
    begin
        prdata = tim_rdata;
        for (int i = 0; i < NUM_PORTS; i++)
            prdata = prdata | port_rdata[i];
    end

endmodule

//--- verilog/pio_port.sv
////////////////////
// One parallel I/O port
// PIN sampling with inversion and pin mask
// DDR and PORT registers, pin drive
////////////////////

module pio_port
    import game_io_pkg::*;
#(
    parameter io_addr_t BASE     = PB_BASE,
    parameter io_data_t PIN_MASK = 8'hFF,
    parameter io_data_t INV_MASK = 8'h00,
    parameter io_data_t OUT_MASK = 8'hFF
)
(
    input  logic     clk,
    input  logic     rst,
    io_bus_if.periph bus,
    input  io_data_t pins,
    output io_data_t rdata,
    output io_data_t drive
);

    localparam io_addr_t DDR_ADDR  = BASE + 8'd1;
    localparam io_addr_t PORT_ADDR = BASE + 8'd2;

    io_data_t pin_q;
    io_data_t ddr;
    io_data_t port;

    // Pin sampler with one cycle of latency
    always_ff @(posedge clk)
    begin
        pin_q <= (pins ^ INV_MASK) & PIN_MASK;
    end

    // Bits outside OUT_MASK stay zero, so an input-only port keeps nothing
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ddr  <= '0;
            port <= '0;
        end
        else if (bus.wr)
        begin
            if (bus.addr == DDR_ADDR)
                ddr <= bus.wdata & OUT_MASK;
            if (bus.addr == PORT_ADDR)
                port <= bus.wdata & OUT_MASK;
        end
    end

    always_comb
    begin
        rdata = '0;
        if (bus.rd)
        begin
            case (bus.addr)
                BASE:      rdata = pin_q;
                DDR_ADDR:  rdata = ddr;
                PORT_ADDR: rdata = port;
                default:   rdata = '0;
            endcase
        end
    end

    assign drive = port & ddr;  // Only pins set as outputs drive

endmodule

//--- verilog/timer8.sv
////////////////////
// Timer 0 with its prescaler
// Normal and CTC counting, compare A and B
// Overflow and compare flags, TIMSK, irq
// OC0A toggle output
////////////////////

module timer8
    import game_io_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    io_bus_if.periph bus,
    output io_data_t rdata,
    output logic     oca,
    output logic     oca_connect,
    output logic     irq
);

    logic [PRESCALE_WIDTH-1:0] presc;
    io_data_t                  tccra;
    io_data_t                  tccrb;
    io_data_t                  tcnt;
    io_data_t                  ocra;
    io_data_t                  ocrb;
    logic [OCFB_BIT:0]         timsk;
    logic [OCFB_BIT:0]         tifr;
    logic [OCFB_BIT:0]         flag_set;
    logic [OCFB_BIT:0]         flag_clr;
    logic [CS_MSB:CS_LSB]      cs;
    logic [1:0]                coma;
    logic                      ctc;
    logic                      tick;
    logic                      wr_tccra;
    logic                      wr_tccrb;
    logic                      wr_tcnt;
    logic                      wr_ocra;
    logic                      wr_ocrb;
    logic                      wr_timsk;
    logic                      wr_tifr;

    assign wr_tccra = bus.wr && (bus.addr == TCCRA_ADDR);
    assign wr_tccrb = bus.wr && (bus.addr == TCCRB_ADDR);
    assign wr_tcnt  = bus.wr && (bus.addr == TCNT_ADDR);
    assign wr_ocra  = bus.wr && (bus.addr == OCRA_ADDR);
    assign wr_ocrb  = bus.wr && (bus.addr == OCRB_ADDR);
    assign wr_timsk = bus.wr && (bus.addr == TIMSK_ADDR);
    assign wr_tifr  = bus.wr && (bus.addr == TIFR_ADDR);

    assign cs   = tccrb[CS_MSB:CS_LSB];
    assign coma = tccra[COMA_MSB:COMA_LSB];
    assign ctc  = tccra[WGM1_BIT];

    // Free-running prescaler
    always_ff @(posedge clk)
    begin
        if (rst)
            presc <= '0;
        else
            presc <= presc + 1'b1;
    end

    always_comb
    begin
        case (cs)
            3'd1:    tick = 1'b1;
            3'd2:    tick = &presc[2:0];  // clk/8
            3'd3:    tick = &presc[5:0];  // clk/64
            3'd4:    tick = &presc[7:0];  // clk/256
            3'd5:    tick = &presc;       // clk/1024
            default: tick = 1'b0;         // Stop and external sources
        endcase
    end

    // Control and compare registers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tccra <= '0;
            tccrb <= '0;
            ocra  <= '0;
            ocrb  <= '0;
            timsk <= '0;
        end
        else
        begin
            if (wr_tccra)
                tccra <= bus.wdata;
            if (wr_tccrb)
                tccrb <= bus.wdata;
            if (wr_ocra)
                ocra <= bus.wdata;
            if (wr_ocrb)
                ocrb <= bus.wdata;
            if (wr_timsk)
                timsk <= bus.wdata[OCFB_BIT:0];
        end
    end

    // A bus write wins over the tick
    always_ff @(posedge clk)
    begin
        if (rst)
            tcnt <= '0;
        else if (wr_tcnt)
            tcnt <= bus.wdata;
        else if (tick)
            tcnt <= (ctc && tcnt == ocra) ? 8'd0 : tcnt + 8'd1;
    end

    assign flag_set[TOV_BIT]  = tick && (tcnt == 8'hFF);
    assign flag_set[OCFA_BIT] = tick && (tcnt == ocra);
    assign flag_set[OCFB_BIT] = tick && (tcnt == ocrb);
    assign flag_clr           = wr_tifr ? bus.wdata[OCFB_BIT:0] : '0;

    // A new event wins over write one to clear
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tifr <= '0;
            irq  <= 1'b0;
            oca  <= 1'b0;
        end
        else
        begin
            tifr <= (tifr & ~flag_clr) | flag_set;
            irq  <= |(tifr & timsk);
            if (flag_set[OCFA_BIT] && coma == 2'b01)
                oca <= ~oca;  // Toggle on compare match
        end
    end

    assign oca_connect = |coma;

    always_comb
    begin
        rdata = '0;
        if (bus.rd)
        begin
            case (bus.addr)
                TCCRA_ADDR: rdata = tccra;
                TCCRB_ADDR: rdata = tccrb;
                TCNT_ADDR:  rdata = tcnt;
                OCRA_ADDR:  rdata = ocra;
                OCRB_ADDR:  rdata = ocrb;
                TIMSK_ADDR: rdata = {5'd0, timsk};
                TIFR_ADDR:  rdata = {5'd0, tifr};
                default:    rdata = '0;
            endcase
        end
    end

endmodule

//--- verilog/game_io_top.sv
////////////////////
// Game board I/O subsystem top level
// APB bridge, ports B to F, timer 0
// Button and LED/buzzer/display pin map
////////////////////

module game_io_top
    import game_io_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  io_addr_t   paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  io_data_t   pwdata,
    output io_data_t   prdata,
    input  logic [5:0] buttons,
    output logic [2:0] rgb,
    output logic       buzzer1,
    output logic       dc,
    output logic       irq
);

    io_data_t [NUM_PORTS-1:0] port_rdata;
    io_data_t                 tim_rdata;
    io_data_t                 pb_pins;
    io_data_t                 pe_pins;
    io_data_t                 pf_pins;
    io_data_t                 pb_drive;
    io_data_t                 pc_drive;
    io_data_t                 pd_drive;
    logic                     oca;
    logic                     oca_connect;

    io_bus_if bus ();

    apb_io_bridge u_bridge (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata),
        .port_rdata(port_rdata), .tim_rdata(tim_rdata),
        .bus(bus)
    );

    // Button B on B4, A on E6, up/right/left/down on F7..F4
    assign pb_pins = {3'b000, buttons[5], 4'b0000};
    assign pe_pins = {1'b0, buttons[4], 6'b000000};
    assign pf_pins = {buttons[3], buttons[0], buttons[1], buttons[2], 4'b0000};

    pio_port #(.BASE(PB_BASE), .PIN_MASK(PB_PIN_MASK), .INV_MASK(PB_INV_MASK),
               .OUT_MASK(PB_OUT_MASK)) port_b (
        .clk(clk), .rst(rst), .bus(bus), .pins(pb_pins),
        .rdata(port_rdata[0]), .drive(pb_drive)
    );

    pio_port #(.BASE(PC_BASE), .PIN_MASK(PC_PIN_MASK), .INV_MASK(PC_INV_MASK),
               .OUT_MASK(PC_OUT_MASK)) port_c (
        .clk(clk), .rst(rst), .bus(bus), .pins(8'h00),
        .rdata(port_rdata[1]), .drive(pc_drive)
    );

    pio_port #(.BASE(PD_BASE), .PIN_MASK(PD_PIN_MASK), .INV_MASK(PD_INV_MASK),
               .OUT_MASK(PD_OUT_MASK)) port_d (
        .clk(clk), .rst(rst), .bus(bus), .pins(8'h00),
        .rdata(port_rdata[2]), .drive(pd_drive)
    );

    // E and F are input only
    pio_port #(.BASE(PE_BASE), .PIN_MASK(PE_PIN_MASK), .INV_MASK(PE_INV_MASK),
               .OUT_MASK(PE_OUT_MASK)) port_e (
        .clk(clk), .rst(rst), .bus(bus), .pins(pe_pins),
        .rdata(port_rdata[3]), .drive()
    );

    pio_port #(.BASE(PF_BASE), .PIN_MASK(PF_PIN_MASK), .INV_MASK(PF_INV_MASK),
               .OUT_MASK(PF_OUT_MASK)) port_f (
        .clk(clk), .rst(rst), .bus(bus), .pins(pf_pins),
        .rdata(port_rdata[4]), .drive()
    );

    timer8 u_timer0 (
        .clk(clk), .rst(rst), .bus(bus), .rdata(tim_rdata),
        .oca(oca), .oca_connect(oca_connect), .irq(irq)
    );

    // Common anode LED where a low lights a colour
    assign rgb[2] = ~pb_drive[6];
    assign rgb[1] = oca_connect ? ~oca : ~pb_drive[7];  // OC0A takes over B7
    assign rgb[0] = ~pb_drive[5];

    assign buzzer1 = pc_drive[6];
    assign dc      = pd_drive[4];  // Display data/command

endmodule

//--- verif/game_io_tb.sv
////////////////////
// Testbench for the game board I/O block
// Clock, reset, APB read and write tasks
// Step table with register, button, pin and timer checks
// Watchdog sized from the table length
////////////////////

module game_io_tb
    import game_io_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_RANGE, OP_BUTTONS, OP_FLAG, OP_PINS, OP_TOGGLES, OP_IDLE
    } op_t;

    // Range rows use data as the lower bound, toggle and idle rows as a cycle count
    typedef struct packed {
        op_t      op;
        io_addr_t addr;
        io_data_t data;
        io_data_t exp;
    } step_t;

    localparam int MAX_STEPS  = 256;
    localparam int POLL_LIMIT = 400;

    localparam logic [4:0][7:0] BASES     = {PF_BASE, PE_BASE, PD_BASE, PC_BASE, PB_BASE};
    localparam logic [4:0][7:0] PIN_MASKS = {PF_PIN_MASK, PE_PIN_MASK, PD_PIN_MASK,
                                             PC_PIN_MASK, PB_PIN_MASK};
    localparam logic [4:0][7:0] INV_MASKS = {PF_INV_MASK, PE_INV_MASK, PD_INV_MASK,
                                             PC_INV_MASK, PB_INV_MASK};
    localparam logic [4:0][7:0] OUT_MASKS = {PF_OUT_MASK, PE_OUT_MASK, PD_OUT_MASK,
                                             PC_OUT_MASK, PB_OUT_MASK};
    localparam logic [6:0][7:0] TIMER_REGS = {TCCRA_ADDR, TCCRB_ADDR, TCNT_ADDR, OCRA_ADDR,
                                              OCRB_ADDR, TIMSK_ADDR, TIFR_ADDR};

    logic       clk;
    logic       rst;
    io_addr_t   paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    io_data_t   pwdata;
    io_data_t   prdata;
    logic [5:0] buttons;
    logic [2:0] rgb;
    logic       buzzer1;
    logic       dc;
    logic       irq;

    step_t           steps [0:MAX_STEPS-1];
    int              n_steps = 0;
    logic            built = 1'b0;
    int              checks = 0;
    int              errors = 0;
    logic [4:0][7:0] ddr_m;   // Expected DDR per port
    logic [4:0][7:0] port_m;  // Expected PORT per port

    game_io_top dut (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata),
        .buttons(buttons), .rgb(rgb), .buzzer1(buzzer1), .dc(dc), .irq(irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input io_data_t got, input io_data_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error %s: got %02h, expected %02h", name, got, exp);
        end
    endtask

    function automatic io_data_t clamp(input io_data_t v, input io_data_t lo, input io_data_t hi);
        if (v < lo)
            return lo;
        if (v > hi)
            return hi;
        return v;
    endfunction

    task automatic apb_write(input io_addr_t a, input io_data_t d);
        @(posedge clk);
        paddr   <= a;
        pwdata  <= d;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);  // Write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input io_addr_t a, output io_data_t d);
        @(posedge clk);
        paddr   <= a;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        d = prdata;  // Mid access cycle
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Button wiring from the board pin map, then inversion and pin mask
    function automatic io_data_t pin_expect(input int p, input logic [5:0] b);
        io_data_t raw;
        raw = '0;
        case (p)
            0: raw[4] = b[5];
            3: raw[6] = b[4];
            4:
            begin
                raw[7] = b[3];
                raw[6] = b[0];
                raw[5] = b[1];
                raw[4] = b[2];
            end
            default: raw = '0;
        endcase
        return (raw ^ INV_MASKS[p]) & PIN_MASKS[p];
    endfunction

    // {rgb, buzzer1, dc, irq} while OC0A is disconnected
    function automatic io_data_t outputs_expect(input logic irq_e);
        io_data_t drv_b;
        io_data_t drv_c;
        io_data_t drv_d;
        drv_b = port_m[0] & ddr_m[0];
        drv_c = port_m[1] & ddr_m[1];
        drv_d = port_m[2] & ddr_m[2];
        return {2'b00, ~drv_b[6], ~drv_b[7], ~drv_b[5], drv_c[6], drv_d[4], irq_e};
    endfunction

    function automatic void add(input op_t op, input io_addr_t a, input io_data_t d,
                                input io_data_t e);
        steps[n_steps] = '{op, a, d, e};
        n_steps++;
    endfunction

    function automatic void add_write(input io_addr_t a, input io_data_t d);
        add(OP_WRITE, a, d, 8'h00);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (a == BASES[p] + 8'd1)
                ddr_m[p] = d & OUT_MASKS[p];
            if (a == BASES[p] + 8'd2)
                port_m[p] = d & OUT_MASKS[p];
        end
    endfunction

    task automatic build_steps();
        io_data_t   d;
        logic [5:0] b;
        ddr_m  = '0;
        port_m = '0;
        // Reset values
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            add(OP_READ, BASES[p] + 8'd1, 8'h00, 8'h00);
            add(OP_READ, BASES[p] + 8'd2, 8'h00, 8'h00);
        end
        for (int r = 0; r < 7; r++)
            add(OP_READ, TIMER_REGS[r], 8'h00, 8'h00);
        add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b0));
        // Random DDR and PORT traffic
        for (int round = 0; round < 3; round++)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                d = $urandom;
                add_write(BASES[p] + 8'd1, d);
                d = $urandom;
                add_write(BASES[p] + 8'd2, d);
                add(OP_READ, BASES[p] + 8'd1, 8'h00, ddr_m[p]);
                add(OP_READ, BASES[p] + 8'd2, 8'h00, port_m[p]);
            end
            add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b0));
        end
        // Buttons onto PINB, PINE, PINF
        for (int n = 0; n < 4; n++)
        begin
            b = $urandom;
            add(OP_BUTTONS, 8'h00, {2'b00, b}, 8'h00);
            add(OP_READ, PB_BASE, 8'h00, pin_expect(0, b));
            add(OP_READ, PE_BASE, 8'h00, pin_expect(3, b));
            add(OP_READ, PF_BASE, 8'h00, pin_expect(4, b));
        end
        // Overflow, irq through TIMSK, write one to clear
        add_write(TIMSK_ADDR, 8'h01);
        add_write(TCNT_ADDR, 8'hFA);
        add_write(TCCRB_ADDR, 8'h01);
        add(OP_FLAG, TIFR_ADDR, 8'h01, 8'h00);
        add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b1));
        add_write(TIMSK_ADDR, 8'h00);
        add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b0));
        add_write(TIMSK_ADDR, 8'h01);
        add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b1));
        add_write(TIFR_ADDR, 8'h01);
        add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b0));
        add_write(TCCRB_ADDR, 8'h00);
        add_write(TIFR_ADDR, 8'h07);
        add(OP_READ, TIFR_ADDR, 8'h00, 8'h00);
        add_write(TIMSK_ADDR, 8'h00);
        // CTC at OCRA 3 with OC0A toggling on rgb[1]
        add_write(TCNT_ADDR, 8'h00);
        add_write(OCRA_ADDR, 8'h03);
        add_write(TCCRA_ADDR, 8'h42);
        add_write(TCCRB_ADDR, 8'h01);
        add(OP_TOGGLES, 8'h00, 8'd20, 8'd2);
        add(OP_FLAG, TIFR_ADDR, 8'h02, 8'h00);
        for (int n = 0; n < 6; n++)
            add(OP_RANGE, TCNT_ADDR, 8'h00, 8'h03);
        add_write(TCCRB_ADDR, 8'h00);
        add_write(TCCRA_ADDR, 8'h00);
        add_write(TIFR_ADDR, 8'h07);
        add(OP_PINS, 8'h00, 8'h00, outputs_expect(1'b0));
        // clk/64 over about 202 counting edges gives 3 or 4 ticks
        add_write(TCNT_ADDR, 8'h00);
        add_write(TCCRB_ADDR, 8'h03);
        add(OP_IDLE, 8'h00, 8'd200, 8'h00);
        add(OP_RANGE, TCNT_ADDR, 8'h03, 8'h04);
        add_write(TCCRB_ADDR, 8'h00);
    endtask

    task automatic run_step(input step_t s);
        io_data_t rd;
        int       polls;
        int       cnt;
        logic     last;
        case (s.op)
            OP_WRITE:   apb_write(s.addr, s.data);
            OP_READ:
            begin
                apb_read(s.addr, rd);
                check($sformatf("prdata[%02h]", s.addr), rd, s.exp);
            end
            OP_RANGE:
            begin
                apb_read(s.addr, rd);
                check($sformatf("prdata[%02h]", s.addr), rd, clamp(rd, s.data, s.exp));
            end
            OP_BUTTONS:
            begin
                @(posedge clk);
                buttons <= s.data[5:0];
            end
            OP_FLAG:
            begin
                rd    = 8'h00;
                polls = 0;
                while ((rd & s.data) == 8'h00 && polls < POLL_LIMIT)
                begin
                    apb_read(s.addr, rd);
                    polls++;
                end
                checks++;
                if ((rd & s.data) == 8'h00)
                begin
                    errors++;
                    $display("Flag %02h in register %02h never came up within %0d polls",
                             s.data, s.addr, POLL_LIMIT);
                end
            end
            OP_PINS:
            begin
                @(posedge clk);
                @(negedge clk);
                check("{rgb,buzzer1,dc,irq}", {2'b00, rgb, buzzer1, dc, irq}, s.exp);
            end
            OP_TOGGLES:
            begin
                cnt = 0;
                @(negedge clk);
                last = rgb[1];
                repeat (s.data)
                begin
                    @(negedge clk);
                    if (rgb[1] !== last)
                        cnt++;
                    last = rgb[1];
                end
                check("rgb[1] toggles", cnt[7:0], clamp(cnt[7:0], s.exp, 8'hFF));
            end
            default:    repeat (s.data) @(posedge clk);
        endcase
    endtask

    initial
    begin
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        buttons = '0;
        void'($urandom(32'h0a9a2fbb));
        build_steps();
        built = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_steps; i++)
            run_step(steps[i]);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Worst case per step is a slow prescaler tick times a long poll
    initial
    begin
        int limit;
        wait (built);
        limit = n_steps * 1024 * 260;
        repeat (limit) @(posedge clk);
        $display("Timeout: the step table did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- game_io.f
verilog/game_io_pkg.sv
verilog/io_bus_if.sv
verilog/apb_io_bridge.sv
verilog/pio_port.sv
verilog/timer8.sv
verilog/game_io_top.sv
verif/game_io_tb.sv
